//--- design/serial_alu_pkg.sv
package serial_alu_pkg;

   // Opcode field width
   localparam int OP_W = 3;

   // Operations of the serial datapath
   typedef enum logic [OP_W-1:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLT  = 3'd5,
      OP_SLTU = 3'd6
   } alu_op_e;

   // One operand bit pair per clock with the LSB first
   typedef struct packed {
      logic op_a;
      logic op_b;
      logic first;
      logic last;
   } alu_bit_t;

   // One result bit per clock
   // cmp only means something on the last slice
   typedef struct packed {
      logic rd;
      logic cmp;
      logic last;
   } alu_res_t;

   // Set-less-than variants return a flag instead of a word
   function automatic logic is_compare(alu_op_e op);
      return (op == OP_SLT) || (op == OP_SLTU);
   endfunction

endpackage

//--- design/operand_sequencer.sv
`timescale 1ns/1ps

module operand_sequencer #(
   parameter int WIDTH = 32
) (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_start,
   input  serial_alu_pkg::alu_op_e  i_op,
   input  logic [WIDTH-1:0]         i_op_a,
   input  logic [WIDTH-1:0]         i_op_b,
   input  logic                     i_done,
   output logic                     o_busy,
   output serial_alu_pkg::alu_op_e  o_op,
   output logic                     o_bit_en,
   output serial_alu_pkg::alu_bit_t o_bit
);

   localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(WIDTH - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOAD,
      ST_SHIFT,
      ST_WAIT
   } seq_state_e;

   seq_state_e       state_q;
   logic [CNT_W-1:0] cnt_q;
   logic [WIDTH-1:0] a_sr;
   logic [WIDTH-1:0] b_sr;
   logic             accept;
   logic             cnt_last;

   // Busy drops in the done cycle so a new start can be taken on that edge
   assign o_busy   = (state_q != ST_IDLE) && !i_done;
   assign accept   = i_start && !o_busy;
   assign cnt_last = (cnt_q == LAST_CNT);
   assign o_bit_en = (state_q == ST_SHIFT);

   always_comb begin
      o_bit.op_a  = a_sr[0];
      o_bit.op_b  = b_sr[0];
      o_bit.first = o_bit_en && (cnt_q == '0);
      o_bit.last  = o_bit_en && cnt_last;
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               state_q <= ST_SHIFT;
               cnt_q   <= '0;
            end
            ST_SHIFT: begin
               cnt_q <= cnt_q + CNT_W'(1);
               if (cnt_last) begin
                  state_q <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               // Collector done and possibly the next request already waiting
               if (i_done) begin
                  state_q <= accept ? ST_LOAD : ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Operands leave LSB first
   always_ff @(posedge clk) begin
      if (accept) begin
         a_sr <= i_op_a;
         b_sr <= i_op_b;
         o_op <= i_op;
      end else if (o_bit_en) begin
         a_sr <= a_sr >> 1;
         b_sr <= b_sr >> 1;
      end
   end

   // Every burst of slices is exactly one word long
   a_burst_len: assert property (@(posedge clk) disable iff (i_reset)
      $rose(o_bit_en) |-> ##WIDTH !o_bit_en);

   // The last marker follows the first one a word later
   a_last_ends: assert property (@(posedge clk) disable iff (i_reset)
      o_bit.first |-> ##(WIDTH-1) o_bit.last);

endmodule

//--- design/serial_alu.sv
`timescale 1ns/1ps

module serial_alu (
   input  logic                     clk,
   input  logic                     i_reset,
   input  serial_alu_pkg::alu_op_e  i_op,
   input  logic                     i_bit_en,
   input  serial_alu_pkg::alu_bit_t i_bit,
   output logic                     o_res_en,
   output serial_alu_pkg::alu_res_t o_res
);

   import serial_alu_pkg::*;

   logic carry_q;
   logic sub;
   logic b_eff;
   logic cin;
   logic sum;
   logic cout;
   logic rd_bit;
   logic lt_now;

   // Subtract and compare both compute a + ~b + 1
   assign sub   = (i_op == OP_SUB) || is_compare(i_op);
   assign b_eff = i_bit.op_b ^ sub;
   assign cin   = i_bit.first ? sub : carry_q;

   // Full adder on the current bit
   assign sum  = i_bit.op_a ^ b_eff ^ cin;
   assign cout = (i_bit.op_a & b_eff) | (cin & (i_bit.op_a ^ b_eff));

   always_comb begin
      case (i_op)
         OP_AND:  rd_bit = i_bit.op_a & i_bit.op_b;
         OP_OR:   rd_bit = i_bit.op_a | i_bit.op_b;
         OP_XOR:  rd_bit = i_bit.op_a ^ i_bit.op_b;
         default: rd_bit = sum;
      endcase
   end

   // Running unsigned less-than is the missing carry out.
   // On the sign bit a signed compare uses the sign of a-b fixed by overflow
   assign lt_now = (i_op == OP_SLT && i_bit.last) ? (sum ^ cin ^ cout) : !cout;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_q  <= 1'b0;
         o_res_en <= 1'b0;
      end else begin
         o_res_en <= i_bit_en;
         if (i_bit_en) begin
            carry_q <= cout;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_bit_en) begin
         o_res.rd   <= rd_bit;
         o_res.cmp  <= lt_now;
         o_res.last <= i_bit.last;
      end
   end

   // Each burst opens with the first slice so the carry gets its preset
   a_res_follow: assert property (@(posedge clk) disable iff (i_reset)
      $rose(i_bit_en) |-> i_bit.first);

endmodule

//--- design/result_collector.sv
`timescale 1ns/1ps

module result_collector #(
   parameter int WIDTH = 32
) (
   input  logic                     clk,
   input  logic                     i_reset,
   input  serial_alu_pkg::alu_op_e  i_op,
   input  logic                     i_res_en,
   input  serial_alu_pkg::alu_res_t i_res,
   output logic                     o_done,
   output logic [WIDTH-1:0]         o_result
);

   import serial_alu_pkg::*;

   // Lower bits of the word so far with the newest bit at the top
   logic [WIDTH-2:0] gather_q;
   logic [WIDTH-1:0] word;
   logic             word_last;

   // Bit 0 arrives first and has travelled to position 0 once the
   // top bit comes in
   assign word      = {i_res.rd, gather_q};
   assign word_last = i_res_en && i_res.last;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_done <= 1'b0;
      end else begin
         o_done <= word_last;
      end
   end

   always_ff @(posedge clk) begin
      if (i_res_en) begin
         gather_q <= word[WIDTH-1:1];
      end
      // Held until the next operation completes
      if (word_last) begin
         if (is_compare(i_op)) begin
            o_result <= {{(WIDTH-1){1'b0}}, i_res.cmp};
         end else begin
            o_result <= word;
         end
      end
   end

   // One pulse per operation
   a_done_pulse: assert property (@(posedge clk) disable iff (i_reset)
      o_done |=> !o_done);

endmodule

//--- design/serial_exec_top.sv
`timescale 1ns/1ps

module serial_exec_top #(
   parameter int WIDTH = 32
) (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_start,
   input  serial_alu_pkg::alu_op_e i_op,
   input  logic [WIDTH-1:0]        i_op_a,
   input  logic [WIDTH-1:0]        i_op_b,
   output logic                    o_busy,
   output logic                    o_done,
   output logic [WIDTH-1:0]        o_result
);

   import serial_alu_pkg::*;

   alu_op_e  op;
   logic     bit_en;
   alu_bit_t bit_slice;
   logic     res_en;
   alu_res_t res;

   operand_sequencer #(
      .WIDTH (WIDTH)
   ) operand_sequencer_inst (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_start  (i_start),
      .i_op     (i_op),
      .i_op_a   (i_op_a),
      .i_op_b   (i_op_b),
      .i_done   (o_done),
      .o_busy   (o_busy),
      .o_op     (op),
      .o_bit_en (bit_en),
      .o_bit    (bit_slice)
   );

   serial_alu serial_alu_inst (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_op     (op),
      .i_bit_en (bit_en),
      .i_bit    (bit_slice),
      .o_res_en (res_en),
      .o_res    (res)
   );

   result_collector #(
      .WIDTH (WIDTH)
   ) result_collector_inst (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_op     (op),
      .i_res_en (res_en),
      .i_res    (res),
      .o_done   (o_done),
      .o_result (o_result)
   );

endmodule

//--- tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One row of the stimulus table
typedef struct packed {
   alu_op_e     op;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] exp;
} vector_t;

localparam int N_FIXED   = 20;
localparam int N_RANDOM  = 28;
localparam int N_VECTORS = N_FIXED + N_RANDOM;

localparam logic [31:0] SEED = 32'd26237;

// Edge cases with expected values worked out by hand
localparam vector_t FIXED_VECTORS [N_FIXED] = '{
   '{OP_ADD,  32'hffffffff, 32'h00000001, 32'h00000000},
   '{OP_ADD,  32'h7fffffff, 32'h00000001, 32'h80000000},
   '{OP_ADD,  32'h00000000, 32'h00000000, 32'h00000000},
   '{OP_SUB,  32'h00000005, 32'h00000007, 32'hfffffffe},
   '{OP_SUB,  32'h00000000, 32'h00000001, 32'hffffffff},
   '{OP_SUB,  32'h89abcdef, 32'h89abcdef, 32'h00000000},
   '{OP_SUB,  32'h00000000, 32'h80000000, 32'h80000000},
   '{OP_AND,  32'hf0f0a5a5, 32'h0ff05a5a, 32'h00f00000},
   '{OP_OR,   32'hf0f0a5a5, 32'h0ff05a5a, 32'hfff0ffff},
   '{OP_XOR,  32'hf0f0a5a5, 32'h0ff05a5a, 32'hff00ffff},
   '{OP_SLT,  32'h80000000, 32'h00000001, 32'h00000001},
   '{OP_SLTU, 32'h80000000, 32'h00000001, 32'h00000000},
   '{OP_SLT,  32'h00000001, 32'h80000000, 32'h00000000},
   '{OP_SLTU, 32'h00000001, 32'h80000000, 32'h00000001},
   '{OP_SLT,  32'hffffffff, 32'h7fffffff, 32'h00000001},
   '{OP_SLTU, 32'hffffffff, 32'h7fffffff, 32'h00000000},
   '{OP_SLT,  32'h12345678, 32'h12345678, 32'h00000000},
   '{OP_SLTU, 32'h12345678, 32'h12345678, 32'h00000000},
   '{OP_SLT,  32'hfffffffe, 32'hffffffff, 32'h00000001},
   '{OP_SLTU, 32'h00000000, 32'h00000000, 32'h00000000}
};

// 32-bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x;
   y = y ^ (y << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

`endif

//--- tests/tb_serial_exec.sv
`timescale 1ns/1ps

module tb_serial_exec;

   import serial_alu_pkg::*;

   `include "tb_vectors.svh"

   localparam int WIDTH         = 32;
   localparam int RESET_CYCLES  = 8;
   localparam int LATENCY       = WIDTH + 2;
   localparam int DONE_TIMEOUT  = 200;
   localparam int QUIET_WINDOW  = WIDTH + 8;

   logic             clk;
   logic             i_reset;
   logic             i_start;
   alu_op_e          i_op;
   logic [WIDTH-1:0] i_op_a;
   logic [WIDTH-1:0] i_op_b;
   logic             o_busy;
   logic             o_done;
   logic [WIDTH-1:0] o_result;

   vector_t     vectors [N_VECTORS];
   logic [31:0] rng_state;
   int          pass_count;
   int          fail_count;

   serial_exec_top #(
      .WIDTH (WIDTH)
   ) serial_exec_top_inst (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_start  (i_start),
      .i_op     (i_op),
      .i_op_a   (i_op_a),
      .i_op_b   (i_op_b),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_result (o_result)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Plain 32-bit arithmetic for the random rows
   function automatic logic [31:0] expected_result(alu_op_e op, logic [31:0] a,
                                                   logic [31:0] b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
         OP_SLTU: return {31'd0, a < b};
         default: return 32'h0;
      endcase
   endfunction

   task automatic build_table();
      logic [31:0] a;
      logic [31:0] b;
      alu_op_e     op;
      rng_state = SEED;
      for (int i = 0; i < N_FIXED; i++) begin
         vectors[i] = FIXED_VECTORS[i];
      end
      for (int i = N_FIXED; i < N_VECTORS; i++) begin
         rng_state = xorshift32(rng_state);
         a = rng_state;
         rng_state = xorshift32(rng_state);
         b = rng_state;
         rng_state = xorshift32(rng_state);
         op = alu_op_e'(3'(rng_state % 7));
         // Shared upper half makes compares decide late
         if (rng_state[4:3] == 2'b00) begin
            b = {a[31:16], b[15:0]};
         end
         vectors[i] = '{op, a, b, expected_result(op, a, b)};
      end
   endtask

   task automatic report_test(input int id, input string what, input bit ok);
      if (ok) begin
         pass_count++;
         $display("Test %0d %s: passed", id, what);
      end else begin
         fail_count++;
         $display("Test %0d %s: failed", id, what);
      end
   endtask

   // Starts one operation at a falling edge and waits for o_done.
   // Returns at the falling edge inside the done cycle.
   task automatic run_op(input int id, input alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b, input bit extra_start,
                         output logic [31:0] result, output bit ok);
      int cycles;
      bit busy_ok;
      ok = 1'b1;
      busy_ok = 1'b1;
      cycles = 0;
      result = '0;
      i_op    = op;
      i_op_a  = a;
      i_op_b  = b;
      i_start = 1'b1;
      @(posedge clk);
      @(negedge clk);
      i_start = 1'b0;
      while (!o_done && cycles < DONE_TIMEOUT) begin
         if (!o_busy) begin
            busy_ok = 1'b0;
         end
         // A start in the middle of the operation
         if (extra_start && cycles == 10) begin
            i_op    = OP_SUB;
            i_op_a  = ~a;
            i_op_b  = 32'h0badf00d;
            i_start = 1'b1;
         end else begin
            i_start = 1'b0;
         end
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end
      i_start = 1'b0;
      if (!o_done) begin
         $display("Test %0d: no o_done within %0d cycles of the start", id, DONE_TIMEOUT);
         ok = 1'b0;
      end else begin
         assert (cycles == LATENCY) else begin
            $display("Test %0d: o_done came %0d edges after the start edge instead of %0d",
                     id, cycles, LATENCY);
            ok = 1'b0;
         end
         assert (busy_ok) else begin
            $display("Test %0d: o_busy went low before o_done", id);
            ok = 1'b0;
         end
         assert (o_busy == 1'b0) else begin
            $display("Fail test %0d: o_busy expected 0 got %h in the done cycle", id, o_busy);
            ok = 1'b0;
         end
         result = o_result;
      end
   endtask

   task automatic check_idle_after_reset();
      bit ok;
      ok = 1'b1;
      for (int n = 0; n < 4; n++) begin
         @(negedge clk);
         assert (o_busy == 1'b0) else begin
            $display("Fail test 0: o_busy expected 0 got %h", o_busy);
            ok = 1'b0;
         end
         assert (o_done == 1'b0) else begin
            $display("Fail test 0: o_done expected 0 got %h", o_done);
            ok = 1'b0;
         end
      end
      report_test(0, "idle after reset", ok);
   endtask

   task automatic apply_vector(input int idx);
      vector_t     vec;
      alu_op_e     op;
      logic [31:0] result;
      bit          ok;
      vec = vectors[idx];
      op = vec.op;
      run_op(idx + 1, op, vec.a, vec.b, 1'b0, result, ok);
      if (ok) begin
         assert (result === vec.exp) else begin
            $display("Fail test %0d: o_result expected %08h got %08h",
                     idx + 1, vec.exp, result);
            ok = 1'b0;
         end
      end
      report_test(idx + 1, $sformatf("%s a=%08h b=%08h", op.name(), vec.a, vec.b), ok);
   endtask

   // A start while busy must change neither the result nor the done count
   task automatic check_ignored_start(input int id);
      logic [31:0] result;
      bit          ok;
      int          extra_dones;
      extra_dones = 0;
      run_op(id, OP_ADD, 32'h11111111, 32'h22222222, 1'b1, result, ok);
      if (ok) begin
         assert (result === 32'h33333333) else begin
            $display("Fail test %0d: o_result expected %08h got %08h",
                     id, 32'h33333333, result);
            ok = 1'b0;
         end
         for (int n = 0; n < QUIET_WINDOW; n++) begin
            @(posedge clk);
            @(negedge clk);
            if (o_done) begin
               extra_dones++;
            end
         end
         assert (extra_dones == 0) else begin
            $display("Test %0d: %0d extra o_done pulses after a start given while busy",
                     id, extra_dones);
            ok = 1'b0;
         end
      end
      report_test(id, "start while busy ignored", ok);
   endtask

   initial begin
      i_reset    = 1'b1;
      i_start    = 1'b0;
      i_op       = OP_ADD;
      i_op_a     = '0;
      i_op_b     = '0;
      pass_count = 0;
      fail_count = 0;
      build_table();
      repeat (RESET_CYCLES) @(negedge clk);
      i_reset = 1'b0;
      check_idle_after_reset();
      // Back to back so each start lands on the edge where o_done falls
      for (int i = 0; i < N_VECTORS; i++) begin
         apply_vector(i);
      end
      check_ignored_start(N_VECTORS + 1);
      $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- compile.f
+incdir+tests
design/serial_alu_pkg.sv
design/operand_sequencer.sv
design/serial_alu.sv
design/result_collector.sv
design/serial_exec_top.sv
tests/tb_serial_exec.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert \
   -f compile.f \
   --top-module tb_serial_exec \
   -o tb_serial_exec > "$BUILD_LOG" 2>&1 \
   && ./obj_dir/tb_serial_exec > "$SIM_LOG" 2>&1 \
   || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "Build or simulation aborted"; exit 1; }

cat "$SIM_LOG"

grep -qF '** FAIL **' "$SIM_LOG" && { echo "Simulation reported failure"; exit 1; }
grep -qF '** PASS **' "$SIM_LOG" || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation passed"
exit 0
